// File: hdl/pdp8_defines.svh
`ifndef PDP8_DEFINES_SVH
`define PDP8_DEFINES_SVH

// Datapath widths
`define PDP8_WORD_W      12
`define PDP8_ADDR_W      12

// 4K words of core
`define PDP8_MEM_DEPTH   4096

// Autoindex registers live at 0010 to 0017 in page zero
`define PDP8_AUTOIDX_LO  12'o0010
`define PDP8_AUTOIDX_HI  12'o0017

`endif

// File: hdl/pdp8_pkg.sv
`include "pdp8_defines.svh"

package pdp8_pkg;

  typedef logic [`PDP8_WORD_W-1:0] word_t;
  typedef logic [`PDP8_ADDR_W-1:0] addr_t;
  typedef logic [`PDP8_ADDR_W-8:0] page_t;  // Address bits above the 7-bit offset

  // Five clocks per major cycle where W waits out the memory read
  typedef enum logic [4:0] {
    F0, FW, F1, F2, F3,
    D0, DW, D1, D2, D3,
    E0, EW, E1, E2, E3,
    H0, HW, H1, H2, H3
  } major_state_t;

  // Top three bits of the instruction word
  typedef enum logic [2:0] {
    AND, TAD, ISZ, DCA, JMS, JMP, IOT, OPR
  } opcode_t;

  typedef struct packed {
    word_t sr;         // Switch register captured with the pulse
    logic  load_addr;
    logic  deposit;
    logic  examine;
    logic  cont;
  } panel_cmd_t;

endpackage

// File: hdl/panel_input.sv
`timescale 1ns/10ps

module panel_input (
  input  logic                   clk,
  input  logic                   reset,
  input  pdp8_pkg::word_t        sr,
  input  logic                   load_addr,
  input  logic                   deposit,
  input  logic                   examine,
  input  logic                   cont,
  input  logic                   halt_req,
  input  pdp8_pkg::major_state_t state,
  output pdp8_pkg::panel_cmd_t   cmd,
  output logic                   run
);
  import pdp8_pkg::*;

  word_t sr_q;
  logic  load_q;
  logic  deposit_q;
  logic  examine_q;
  logic  cont_q;
  logic  take;

  assign take = (state == H1);  // One command per halt cycle

  always_ff @(posedge clk) begin
    if (load_addr || deposit) begin
      sr_q <= sr;  // Hold switches with the command
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      load_q    <= 1'b0;
      deposit_q <= 1'b0;
      examine_q <= 1'b0;
      cont_q    <= 1'b0;
      run       <= 1'b0;
    end else begin
      // A pulse stays pending until H1 has used it
      load_q    <= (load_q && !take) || load_addr;
      deposit_q <= (deposit_q && !take) || deposit;
      examine_q <= (examine_q && !take) || examine;
      cont_q    <= (cont_q && !take) || cont;
      if (halt_req) begin
        run <= 1'b0;
      end else if (take && cont_q) begin
        run <= 1'b1;
      end
    end
  end

  assign cmd = '{sr: sr_q, load_addr: load_q, deposit: deposit_q,
                 examine: examine_q, cont: cont_q};

  assert property (@(posedge clk) disable iff (reset) !(deposit && examine))
    else $error("deposit and examine pulsed in the same clock");

endmodule

// File: hdl/major_state.sv
`timescale 1ns/10ps

module major_state (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   run,
  input  pdp8_pkg::word_t        instruction,
  output pdp8_pkg::major_state_t state
);
  import pdp8_pkg::*;

  opcode_t      opcode;
  logic         indirect;
  logic         mem_ref;
  major_state_t state_next;

  assign opcode   = opcode_t'(instruction[11:9]);
  assign indirect = instruction[8];
  assign mem_ref  = (opcode != IOT) && (opcode != OPR);  // AND through JMP

  always_comb begin
    state_next = state;
    case (state)
      F0: state_next = FW;
      FW: state_next = F1;
      F1: state_next = F2;
      F2: state_next = F3;
      F3: begin
        if (!run) begin
          state_next = H0;
        end else if (mem_ref && indirect) begin
          state_next = D0;
        end else if (mem_ref && opcode != JMP) begin
          state_next = E0;
        end else begin
          state_next = F0;  // Direct JMP and operate group
        end
      end
      D0: state_next = DW;
      DW: state_next = D1;
      D1: state_next = D2;
      D2: state_next = D3;
      D3: begin
        // Indirect JMP is complete once the pointer is in the address register
        if (opcode != JMP) begin
          state_next = E0;
        end else begin
          state_next = run ? F0 : H0;
        end
      end
      E0: state_next = EW;
      EW: state_next = E1;
      E1: state_next = E2;
      E2: state_next = E3;
      E3: state_next = run ? F0 : H0;
      H0: state_next = HW;
      HW: state_next = H1;
      H1: state_next = H2;
      H2: state_next = H3;
      H3: state_next = run ? F0 : H0;
      default: state_next = H0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= H0;
    end else begin
      state <= state_next;
    end
  end

  assert property (@(posedge clk) disable iff (reset)
    !$isunknown(state) && (state <= H3))
    else $error("major state left the legal encodings");

endmodule

// File: hdl/mem_addr.sv
`timescale 1ns/10ps
`include "pdp8_defines.svh"

module mem_addr (
  input  logic                   clk,
  input  logic                   reset,
  input  pdp8_pkg::major_state_t state,
  input  pdp8_pkg::panel_cmd_t   cmd,
  input  pdp8_pkg::word_t        ac,
  input  pdp8_pkg::word_t        rdata,
  output pdp8_pkg::addr_t        addr,
  output pdp8_pkg::word_t        wdata,
  output logic                   write_en,
  output pdp8_pkg::word_t        instruction,
  output pdp8_pkg::word_t        mdout
);
  import pdp8_pkg::*;

  addr_t   pc;
  addr_t   next_pc;
  addr_t   skip_pc;
  addr_t   eff_addr;
  page_t   current_page;
  word_t   mdin;
  logic    index;
  logic    we_q;
  logic    step_addr;
  opcode_t opcode;

  assign opcode   = opcode_t'(instruction[11:9]);
  assign eff_addr = {instruction[7] ? current_page : page_t'(0), instruction[6:0]};

  // Panel deposit goes straight from the switch register
  assign write_en = we_q || (state == H1 && cmd.deposit && !cmd.load_addr);
  assign wdata    = (state == H1) ? cmd.sr : mdin;

  always_ff @(posedge clk) begin
    if (reset) begin
      addr        <= '0;
      pc          <= '0;
      instruction <= 12'o7000;  // NOP
      index       <= 1'b0;
      we_q        <= 1'b0;
      step_addr   <= 1'b0;
    end else begin
      we_q <= 1'b0;
      case (state)
        F0: pc <= addr;
        FW: instruction <= rdata;
        F3: begin
          if (opcode == IOT || opcode == OPR) begin
            addr <= next_pc;
          end else begin
            addr <= eff_addr;  // Operand, pointer or JMP target
          end
        end
        D0: index <= (addr >= `PDP8_AUTOIDX_LO) && (addr <= `PDP8_AUTOIDX_HI);
        DW: we_q <= index;  // Pointer write-back in D1
        D3: begin
          addr  <= index ? mdin : mdout;  // Incremented pointer for autoindex
          index <= 1'b0;
        end
        EW: we_q <= (opcode == ISZ) || (opcode == DCA) || (opcode == JMS);
        E3: addr <= next_pc;
        H1: begin
          if (cmd.load_addr) begin
            addr <= cmd.sr;
          end
          step_addr <= !cmd.load_addr && (cmd.deposit || cmd.examine);
        end
        H2: begin
          if (step_addr) begin
            addr <= addr + 12'd1;
          end
          step_addr <= 1'b0;
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    case (state)
      FW: mdout <= rdata;
      F1: begin
        current_page <= pc[11:7];
        next_pc      <= pc + 12'd1;
        skip_pc      <= pc + 12'd2;
      end
      DW: begin
        mdout <= rdata;
        mdin  <= rdata + 12'd1;  // Next pointer value
      end
      EW: begin
        mdout <= rdata;
        case (opcode)
          ISZ: mdin <= rdata + 12'd1;
          DCA: mdin <= ac;
          JMS: mdin <= next_pc;  // Return address
          default: ;
        endcase
      end
      E1: begin
        if (opcode == ISZ && mdout == 12'o7777) begin
          next_pc <= skip_pc;
        end
      end
      E2: begin
        if (opcode == JMS) begin
          next_pc <= addr + 12'd1;  // Subroutine body follows its entry word
        end
      end
      HW: mdout <= rdata;  // Examine lamp
      default: ;
    endcase
  end

  // Write strobes come from flags set one state earlier
  assert property (@(posedge clk) disable iff (reset)
    write_en |-> (state inside {D1, E1, H1}))
    else $error("memory write outside D1, E1 or H1");

endmodule

// File: hdl/acc_unit.sv
`timescale 1ns/10ps
`include "pdp8_defines.svh"

module acc_unit (
  input  logic                   clk,
  input  logic                   reset,
  input  pdp8_pkg::major_state_t state,
  input  pdp8_pkg::word_t        instruction,
  input  pdp8_pkg::word_t        mdout,
  output pdp8_pkg::word_t        ac,
  output logic                   link,
  output logic                   halt_req
);
  import pdp8_pkg::*;

  opcode_t               opcode;
  logic                  group1;
  logic                  group2;
  logic [`PDP8_WORD_W:0] tad_sum;
  word_t                 opr_ac;
  logic                  opr_carry;

  assign opcode  = opcode_t'(instruction[11:9]);
  assign group1  = (opcode == OPR) && !instruction[8];
  assign group2  = (opcode == OPR) && instruction[8] && !instruction[0];
  assign tad_sum = {1'b0, ac} + {1'b0, mdout};

  always_comb begin
    opr_ac    = ac;
    opr_carry = 1'b0;
    if (instruction[7]) begin
      opr_ac = '0;  // CLA
    end
    if (group1 && instruction[5]) begin
      opr_ac = ~opr_ac;  // CMA
    end
    if (group1 && instruction[0]) begin
      {opr_carry, opr_ac} = {1'b0, opr_ac} + 1'b1;  // IAC
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      ac       <= '0;
      link     <= 1'b0;
      halt_req <= 1'b0;
    end else begin
      // HLT flagged during F2 so run is already low when F3 picks the next cycle
      halt_req <= (state == F1) && group2 && instruction[1];
      case (state)
        F3: begin
          if (group1 || group2) begin
            ac   <= opr_ac;
            link <= link ^ opr_carry;
          end
        end
        E2: begin
          case (opcode)
            AND: ac <= ac & mdout;
            TAD: begin
              ac   <= tad_sum[`PDP8_WORD_W-1:0];
              link <= link ^ tad_sum[`PDP8_WORD_W];  // Carry complements link
            end
            DCA: ac <= '0;  // Stored during E1
            default: ;
          endcase
        end
        default: ;
      endcase
    end
  end

endmodule

// File: hdl/core_mem.sv
`timescale 1ns/10ps
`include "pdp8_defines.svh"

module core_mem (
  input  logic            clk,
  input  pdp8_pkg::addr_t addr,
  input  pdp8_pkg::word_t wdata,
  input  logic            write_en,
  output pdp8_pkg::word_t rdata
);
  import pdp8_pkg::*;

  word_t mem [`PDP8_MEM_DEPTH];

  // Single port, registered read, new data on a write
  always_ff @(posedge clk) begin
    if (write_en) begin
      mem[addr] <= wdata;
      rdata     <= wdata;
    end else begin
      rdata <= mem[addr];
    end
  end

endmodule

// File: hdl/pdp8_top.sv
`timescale 1ns/10ps

module pdp8_top (
  input  logic            clk,
  input  logic            reset,
  input  pdp8_pkg::word_t sr,
  input  logic            load_addr,
  input  logic            deposit,
  input  logic            examine,
  input  logic            cont,
  output pdp8_pkg::addr_t addr_lamp,
  output pdp8_pkg::word_t mdout,
  output pdp8_pkg::word_t ac,
  output logic            link,
  output logic            run
);
  import pdp8_pkg::*;

  panel_cmd_t   cmd;
  major_state_t state;
  word_t        instruction;
  word_t        wdata;
  word_t        rdata;
  logic         write_en;
  logic         halt_req;

  panel_input u_panel (
    .clk       (clk),
    .reset     (reset),
    .sr        (sr),
    .load_addr (load_addr),
    .deposit   (deposit),
    .examine   (examine),
    .cont      (cont),
    .halt_req  (halt_req),
    .state     (state),
    .cmd       (cmd),
    .run       (run)
  );

  major_state u_seq (
    .clk         (clk),
    .reset       (reset),
    .run         (run),
    .instruction (instruction),
    .state       (state)
  );

  mem_addr u_ma (
    .clk         (clk),
    .reset       (reset),
    .state       (state),
    .cmd         (cmd),
    .ac          (ac),
    .rdata       (rdata),
    .addr        (addr_lamp),  // Address register drives the lamps too
    .wdata       (wdata),
    .write_en    (write_en),
    .instruction (instruction),
    .mdout       (mdout)
  );

  acc_unit u_acc (
    .clk         (clk),
    .reset       (reset),
    .state       (state),
    .instruction (instruction),
    .mdout       (mdout),
    .ac          (ac),
    .link        (link),
    .halt_req    (halt_req)
  );

  core_mem u_mem (
    .clk      (clk),
    .addr     (addr_lamp),
    .wdata    (wdata),
    .write_en (write_en),
    .rdata    (rdata)
  );

endmodule

// File: sim/tb_pdp8.sv
`timescale 1ns/10ps
`include "pdp8_defines.svh"

module tb_pdp8;
  import pdp8_pkg::*;

  localparam int CMD_GAP    = 12;     // Covers a command that just missed H1
  localparam int MAX_CYCLES = 20000;  // About ten times the full run

  logic  clk;
  logic  reset;
  word_t sr;
  logic  load_addr;
  logic  deposit;
  logic  examine;
  logic  cont;
  addr_t addr_lamp;
  word_t mdout;
  word_t ac;
  logic  link;
  logic  run;

  word_t  model_mem [`PDP8_MEM_DEPTH];
  bit     model_valid [`PDP8_MEM_DEPTH];
  word_t  model_ac;
  logic   model_link;
  addr_t  exp_addr;
  word_t  exp_mdout;
  word_t  exp_ac;
  logic   exp_link;
  logic   chk_addr;
  logic   chk_mdout;
  logic   chk_acc;
  integer seed;
  int     cycles;
  word_t  words [$];

  pdp8_top DUT (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      fail_run("Timeout, the run did not finish within the cycle limit");
    end
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1, "stopping after first error");
  endtask

  task automatic report_mismatch(input string name, input word_t got, input word_t want);
    $display("CHECK FAILED at %0t: %s = %o, expected %o", $time, name, got, want);
    fail_run("lamp value differs from the reference model");
  endtask

  // Lamps are sampled on the falling edge away from input changes
  assert property (@(negedge clk) disable iff (reset) chk_addr |-> addr_lamp == exp_addr)
    else report_mismatch("addr_lamp", addr_lamp, exp_addr);
  assert property (@(negedge clk) disable iff (reset) chk_mdout |-> mdout == exp_mdout)
    else report_mismatch("mdout", mdout, exp_mdout);
  assert property (@(negedge clk) disable iff (reset) chk_acc |-> ac == exp_ac)
    else report_mismatch("ac", ac, exp_ac);
  assert property (@(negedge clk) disable iff (reset) chk_acc |-> link == exp_link)
    else report_mismatch("link", word_t'(link), word_t'(exp_link));
  assert property (@(negedge clk) disable iff (reset) chk_addr |-> !run)
    else fail_run("run is high while the panel is in use");

  task automatic model_write(input addr_t a, input word_t w);
    model_mem[a]   = w;
    model_valid[a] = 1'b1;
  endtask

  // Instruction-level model of the supported subset that runs until HLT
  task automatic model_exec(input addr_t start, output addr_t stop_pc);
    addr_t       pc;
    addr_t       ea;
    word_t       ir;
    logic [12:0] sum;
    bit          halted;
    int          steps;
    pc     = start;
    halted = 1'b0;
    steps  = 0;
    while (!halted) begin
      if (steps > 1000) begin
        fail_run("reference model never reached HLT");
      end
      ir = model_mem[pc];
      ea = {ir[7] ? pc[11:7] : 5'b0, ir[6:0]};  // Page of the instruction itself
      pc = pc + 12'd1;
      if (ir[11:9] < 3'd6 && ir[8]) begin
        if (ea >= `PDP8_AUTOIDX_LO && ea <= `PDP8_AUTOIDX_HI) begin
          model_write(ea, model_mem[ea] + 12'd1);  // Pre-increment
        end
        ea = model_mem[ea];
      end
      case (opcode_t'(ir[11:9]))
        AND: model_ac = model_ac & model_mem[ea];
        TAD: begin
          sum        = {1'b0, model_ac} + {1'b0, model_mem[ea]};
          model_ac   = sum[11:0];
          model_link = model_link ^ sum[12];
        end
        ISZ: begin
          model_write(ea, model_mem[ea] + 12'd1);
          if (model_mem[ea] == 12'o0000) begin
            pc = pc + 12'd1;
          end
        end
        DCA: begin
          model_write(ea, model_ac);
          model_ac = '0;
        end
        JMS: begin
          model_write(ea, pc);
          pc = ea + 12'd1;
        end
        JMP: pc = ea;
        OPR: begin
          if (ir[7]) begin
            model_ac = '0;
          end
          if (!ir[8] && ir[5]) begin
            model_ac = ~model_ac;
          end
          if (!ir[8] && ir[0]) begin
            sum        = {1'b0, model_ac} + 13'd1;
            model_ac   = sum[11:0];
            model_link = model_link ^ sum[12];
          end
          if (ir[8] && ir[1]) begin
            halted = 1'b1;
          end
        end
        default: ;
      endcase
      steps++;
    end
    stop_pc = pc;
  endtask

  // kind is {load_addr, deposit, examine, cont}
  task automatic send_pulse(input logic [3:0] kind, input word_t value);
    chk_addr  = 1'b0;
    chk_mdout = 1'b0;
    sr        = value;
    {load_addr, deposit, examine, cont} = kind;
    @(posedge clk);
    #1;
    {load_addr, deposit, examine, cont} = 4'b0000;
  endtask

  task automatic settle_lamps();
    repeat (CMD_GAP) @(posedge clk);
    #1;
    chk_addr = 1'b1;
    if (model_valid[exp_addr]) begin
      exp_mdout = model_mem[exp_addr];
      chk_mdout = 1'b1;
    end
    @(posedge clk);  // Lamps stay armed across one falling edge
    #1;
  endtask

  task automatic load_address(input addr_t a);
    send_pulse(4'b1000, a);
    exp_addr = a;
    settle_lamps();
  endtask

  task automatic deposit_word(input word_t w);
    model_write(exp_addr, w);
    send_pulse(4'b0100, w);
    exp_addr = exp_addr + 12'd1;
    settle_lamps();
  endtask

  task automatic examine_next();
    send_pulse(4'b0010, '0);
    exp_addr = exp_addr + 12'd1;
    settle_lamps();
  endtask

  task automatic deposit_block(input addr_t start, input word_t data [$]);
    load_address(start);
    foreach (data[i]) begin
      deposit_word(data[i]);
    end
  endtask

  // Loads the address and checks the word against a fixed value
  task automatic expect_word(input addr_t a, input word_t w);
    load_address(a);
    exp_mdout = w;
    chk_mdout = 1'b1;
    @(posedge clk);
    #1;
  endtask

  task automatic wait_run(input logic level, input int limit, input string why);
    int n;
    n = 0;
    while (run !== level) begin
      if (n >= limit) begin
        fail_run(why);
      end
      @(posedge clk);
      #1;
      n++;
    end
  endtask

  task automatic run_program(input addr_t start);
    addr_t stop_pc;
    model_exec(start, stop_pc);
    load_address(start);
    chk_acc = 1'b0;
    send_pulse(4'b0001, '0);
    wait_run(1'b1, 20, "run did not rise after cont");
    wait_run(1'b0, 4000, "program did not reach HLT");
    exp_ac   = model_ac;
    exp_link = model_link;
    exp_addr = stop_pc;
    settle_lamps();
    chk_acc = 1'b1;
  endtask

  initial begin
    seed       = 54299;
    cycles     = 0;
    reset      = 1'b1;
    sr         = '0;
    load_addr  = 1'b0;
    deposit    = 1'b0;
    examine    = 1'b0;
    cont       = 1'b0;
    chk_addr   = 1'b0;
    chk_mdout  = 1'b0;
    chk_acc    = 1'b0;
    model_ac   = '0;
    model_link = 1'b0;
    repeat (5) @(posedge clk);
    #1;
    reset    = 1'b0;
    exp_addr = '0;
    exp_ac   = '0;
    exp_link = 1'b0;
    settle_lamps();
    chk_acc = 1'b1;

    // Deposits with auto-increment, then read back by examine
    load_address(12'o0100);
    for (int i = 0; i < 16; i++) begin
      deposit_word(word_t'($random(seed)));
    end
    load_address(12'o0100);
    repeat (16) examine_next();

    // TAD, AND, DCA and operate group
    words = '{word_t'($random(seed)), word_t'($random(seed)), word_t'($random(seed)), 0};
    deposit_block(12'o0250, words);
    words = '{12'o7200, 12'o1250, 12'o1251, 12'o0252, 12'o3253,
              12'o7240, 12'o7001, 12'o1250, 12'o7402};
    deposit_block(12'o0200, words);
    run_program(12'o0200);
    load_address(12'o0253);
    examine_next();

    // ISZ counting loop around a JMS subroutine
    words = '{12'o7773, 12'o0000, word_t'($random(seed)), word_t'($random(seed))};
    deposit_block(12'o0460, words);
    words = '{12'o0000, 12'o1263, 12'o5670};
    deposit_block(12'o0470, words);
    words = '{12'o7200, 12'o1260, 12'o3261, 12'o4270, 12'o2261,
              12'o5203, 12'o1262, 12'o7402};
    deposit_block(12'o0400, words);
    run_program(12'o0400);
    expect_word(12'o0461, 12'o0000);
    expect_word(12'o0470, 12'o0404);

    // Autoindex pointer at 0010 and a current-page indirect pointer
    words = '{12'o0677};
    deposit_block(12'o0010, words);
    words = '{12'o0701};
    deposit_block(12'o0640, words);
    words = '{word_t'($random(seed)), word_t'($random(seed)), 0};
    deposit_block(12'o0700, words);
    words = '{12'o7200, 12'o1410, 12'o1410, 12'o3410, 12'o1640, 12'o7402};
    deposit_block(12'o0600, words);
    run_program(12'o0600);
    load_address(12'o0010);
    load_address(12'o0700);
    examine_next();
    examine_next();

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

// File: sources.f
+incdir+hdl
hdl/pdp8_pkg.sv
hdl/panel_input.sv
hdl/major_state.sv
hdl/mem_addr.sv
hdl/acc_unit.sv
hdl/core_mem.sv
hdl/pdp8_top.sv
sim/tb_pdp8.sv
